/* dcache.f */
+incdir+verilog
verilog/core_defs_pkg.sv
verilog/dcache_controller.sv
verilog/cache_set.sv
verilog/way_select.sv
verilog/dcache.sv
verif/dcache_mem_model.sv
verif/dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the dcache testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f dcache.f --top-module dcache_tb -o dcache_sim

# A failing run exits nonzero, the log check below gives the verdict
./obj_dir/dcache_sim 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "dcache: FAILED"
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    echo "dcache: no result reported"
    exit 1
fi
echo "dcache: PASSED"

/* verif/dcache_tb.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_tb;

    import core_defs_pkg::*;

    localparam int PERIOD     = 40;
    localparam int WORDS      = 4096;
    localparam int MAX_CYCLES = 4000;  // About 60 accesses of under 30 cycles, with margin

    logic       clock;
    logic       reset;
    data_addr_t addr;
    logic       re;
    logic       we;
    byte_mask_t be;
    data_t      wdata;
    data_t      rdata;
    logic       busy;
    logic       hit;
    data_addr_t mem_addr;
    logic       mem_re;
    logic       mem_we;
    byte_mask_t mem_be;
    data_t      mem_wdata;
    data_t      mem_rdata;
    logic       mem_busy;
    int         read_count;
    int         write_count;

    // Shadow of memory, resident lines and the round-robin pointer
    data_t       exp_mem   [WORDS];
    tag_t        res_tag   [`DCACHE_WAYS][`DCACHE_LINES];
    logic        res_valid [`DCACHE_WAYS][`DCACHE_LINES];
    int          victim_way  = 0;
    int          cycle_count = 0;
    logic [31:0] rand_state  = 32'h75bf;

    dcache uut (
        .i_clock(clock), .i_reset(reset), .i_addr(addr), .i_re(re), .i_we(we),
        .i_be(be), .i_wdata(wdata), .o_rdata(rdata), .o_busy(busy), .o_hit(hit),
        .o_mem_addr(mem_addr), .o_mem_re(mem_re), .o_mem_we(mem_we), .o_mem_be(mem_be),
        .o_mem_wdata(mem_wdata), .i_mem_rdata(mem_rdata), .i_mem_busy(mem_busy)
    );

    dcache_mem_model mem (
        .i_clock(clock), .i_reset(reset), .i_addr(mem_addr), .i_re(mem_re), .i_we(mem_we),
        .i_be(mem_be), .i_wdata(mem_wdata), .o_rdata(mem_rdata), .o_busy(mem_busy),
        .o_read_count(read_count), .o_write_count(write_count)
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD/2) clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: no result after %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL time %0t %s expected %h actual %h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] stepped;
        stepped = state >> 1;
        if (state[0])
            stepped = stepped ^ 32'h8020_0003;
        return stepped;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int k = 0; k < n; k++) begin
            value      = {value[30:0], rand_state[0]};
            rand_state = lfsr_next(rand_state);    // One step per bit
        end
        return value;
    endfunction

    function automatic data_addr_t build_addr(input int tag, input int index, input int offset);
        data_addr_u u;
        u.fields.tag      = tag_t'(tag);
        u.fields.index    = index_t'(index);
        u.fields.offset   = offset_t'(offset);
        u.fields.byte_off = 2'b00;
        return u.flat;
    endfunction

    function automatic int word_index(input data_addr_t a);
        return int'(a[13:2]);
    endfunction

    function automatic int resident_way(input data_addr_t a);
        data_addr_u u;
        u.flat = a;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (res_valid[w][u.fields.index] && res_tag[w][u.fields.index] == u.fields.tag)
                return w;
        end
        return -1;
    endfunction

    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input byte_mask_t m);
        data_t merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (m[b])
                merged[8*b +: 8] = new_word[8*b +: 8];
        end
        return merged;
    endfunction

    task automatic read_access(input data_addr_t a);
        data_addr_u u;
        int         way;
        int         reads_before;
        logic       first_busy;
        u.flat       = a;
        way          = resident_way(a);
        reads_before = read_count;
        @(negedge clock);
        addr = a;
        re   = 1'b1;
        #(PERIOD/4);
        first_busy = busy;
        while (busy) begin
            @(negedge clock);
            #(PERIOD/4);
        end
        expect_equal("o_busy in request cycle", 32'(way < 0), 32'(first_busy));
        expect_equal("o_hit", 1, 32'(hit));
        expect_equal("o_rdata", exp_mem[word_index(a)], rdata);
        expect_equal("memory reads", (way < 0) ? `DCACHE_BLOCK : 0, 32'(read_count - reads_before));
        if (way < 0) begin
            res_valid[victim_way][u.fields.index] = 1'b1;  // Line lands in the victim way
            res_tag[victim_way][u.fields.index]   = u.fields.tag;
            victim_way = (victim_way + 1) % `DCACHE_WAYS;
        end
        @(negedge clock);
        re = 1'b0;
    endtask

    task automatic write_access(input data_addr_t a, input byte_mask_t m, input data_t d);
        int   writes_before;
        int   reads_before;
        logic first_busy;
        writes_before = write_count;
        reads_before  = read_count;
        @(negedge clock);
        addr  = a;
        be    = m;
        wdata = d;
        we    = 1'b1;
        #(PERIOD/4);
        first_busy = busy;
        while (busy) begin
            @(negedge clock);
            #(PERIOD/4);
        end
        @(negedge clock);                          // Memory took the word on the last edge
        we = 1'b0;
        exp_mem[word_index(a)] = merge_bytes(exp_mem[word_index(a)], d, m);
        expect_equal("o_busy in request cycle", 1, 32'(first_busy));
        expect_equal("memory writes", 1, 32'(write_count - writes_before));
        expect_equal("memory reads", 0, 32'(read_count - reads_before));
        expect_equal("memory word", exp_mem[word_index(a)], mem.words[word_index(a)]);
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------

    task automatic reset_clear_test();
        @(negedge clock);
        #(PERIOD/4);
        expect_equal("o_mem_re", 0, 32'(mem_re));
        expect_equal("o_mem_we", 0, 32'(mem_we));
        read_access(build_addr(0, 0, 0));          // Issued during the sweep
        expect_equal("memory writes", 0, 32'(write_count));
    endtask

    task automatic line_fill_test();
        read_access(build_addr(4, 1, 1));
        for (int k = 0; k < `DCACHE_BLOCK; k++) begin
            if (k != 1)
                read_access(build_addr(4, 1, k));
        end
    endtask

    task automatic write_through_test();
        write_access(build_addr(4, 1, 2), 4'b0101, 32'h1122_3344);
        read_access(build_addr(4, 1, 2));          // Merged word from the cache
        write_access(build_addr(6, 2, 3), 4'b1100, 32'hDEAD_BEEF);
        read_access(build_addr(6, 2, 3));          // No allocate on write miss
    endtask

    task automatic replacement_test();
        data_addr_t evicted;
        read_access(build_addr(1, 5, 0));
        read_access(build_addr(2, 5, 1));
        read_access(build_addr(1, 5, 2));
        read_access(build_addr(2, 5, 3));
        evicted = build_addr(int'(res_tag[victim_way][5]), 5, 0);
        read_access(build_addr(3, 5, 0));
        read_access(evicted);
    endtask

    task automatic back_pressure_test();
        logic [31:0] op;
        logic [31:0] tag;
        logic [31:0] idx;
        logic [31:0] off;
        logic [31:0] m;
        data_addr_t  a;
        for (int n = 0; n < 40; n++) begin
            op  = rand_bits(1);
            tag = rand_bits(2);
            idx = rand_bits(3);
            off = rand_bits(2);
            a   = build_addr(int'(tag) + 8, int'(idx), int'(off));
            if (op[0]) begin
                m = rand_bits(4);
                if (m[3:0] == 4'h0)
                    m = 32'hF;
                write_access(a, m[3:0], rand_bits(32));
            end else begin
                read_access(a);
            end
        end
        for (int i = 0; i < WORDS; i++)
            expect_equal("final memory word", exp_mem[i], mem.words[i]);
    endtask

    initial begin
        reset = 1'b1;
        addr  = '0;
        re    = 1'b0;
        we    = 1'b0;
        be    = '0;
        wdata = '0;
        for (int i = 0; i < WORDS; i++)
            exp_mem[i] = 32'(i) ^ 32'hA5A5_0000;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            for (int l = 0; l < `DCACHE_LINES; l++)
                res_valid[w][l] = 1'b0;
        end
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        reset_clear_test();
        line_fill_test();
        write_through_test();
        replacement_test();
        back_pressure_test();

        $display("Simulation passed");
        $finish;
    end

endmodule

/* verif/dcache_mem_model.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_mem_model (
    input  logic                      i_clock,
    input  logic                      i_reset,
    input  core_defs_pkg::data_addr_t i_addr,
    input  logic                      i_re,
    input  logic                      i_we,
    input  core_defs_pkg::byte_mask_t i_be,
    input  core_defs_pkg::data_t      i_wdata,
    output core_defs_pkg::data_t      o_rdata,
    output logic                      o_busy,         // Transfer stalls while high
    output int                        o_read_count,   // Accepted reads
    output int                        o_write_count   // Accepted writes
);

    import core_defs_pkg::*;

    localparam int WORDS = 4096;

    data_t       words [WORDS];
    logic [31:0] lfsr;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] stepped;
        stepped = state >> 1;
        if (state[0])
            stepped = stepped ^ 32'h8020_0003;     // Taps 32, 22, 2, 1
        return stepped;
    endfunction

    initial begin
        for (int i = 0; i < WORDS; i++)
            words[i] = 32'(i) ^ 32'hA5A5_0000;
    end

    assign o_rdata = words[i_addr[13:2]];          // Word address

    always @(posedge i_clock) begin
        if (i_reset) begin
            lfsr          <= 32'h75bf;
            o_busy        <= 1'b1;
            o_read_count  <= 0;
            o_write_count <= 0;
        end else begin
            lfsr   <= lfsr_next(lfsr);
            o_busy <= lfsr[0];                     // One LFSR bit per cycle
            if (i_re && !o_busy)
                o_read_count <= o_read_count + 1;
            if (i_we && !o_busy) begin
                o_write_count <= o_write_count + 1;
                for (int b = 0; b < 4; b++) begin
                    if (i_be[b])
                        words[i_addr[13:2]][8*b +: 8] <= i_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* verilog/dcache.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache (
    // Clock and reset
    input  logic                      i_clock,
    input  logic                      i_reset,

    // CPU port
    input  core_defs_pkg::data_addr_t i_addr,       // Byte address
    input  logic                      i_re,         // Read request
    input  logic                      i_we,         // Write request
    input  core_defs_pkg::byte_mask_t i_be,         // Write byte enables
    input  core_defs_pkg::data_t      i_wdata,      // Write data
    output core_defs_pkg::data_t      o_rdata,      // Read data
    output logic                      o_busy,       // Access not finished
    output logic                      o_hit,        // Read hit

    // Memory port
    output core_defs_pkg::data_addr_t o_mem_addr,
    output logic                      o_mem_re,
    output logic                      o_mem_we,
    output core_defs_pkg::byte_mask_t o_mem_be,
    output core_defs_pkg::data_t      o_mem_wdata,
    input  core_defs_pkg::data_t      i_mem_rdata,
    input  logic                      i_mem_busy
);

    import core_defs_pkg::*;

    data_addr_u cpu_addr;                      // CPU address seen as fields
    data_addr_u mem_addr;                      // Controller fields seen flat
    way_req_t   ctrl_req;
    logic       ctrl_busy;
    way_resp_t  way_resp [`DCACHE_WAYS];
    logic       sel_hit;
    logic [`DCACHE_WAYS-1:0] sel_hit_way;

    assign cpu_addr.flat = i_addr;

    // Memory always addresses whole words
    assign mem_addr.fields = '{tag: ctrl_req.tag, index: ctrl_req.index,
                               offset: ctrl_req.offset, byte_off: 2'b00};
    assign o_mem_addr  = mem_addr.flat;
    assign o_mem_be    = i_be;
    assign o_mem_wdata = i_wdata;

    assign o_busy = ctrl_busy & (i_re | i_we);
    assign o_hit  = sel_hit & i_re & ~ctrl_busy;  // Only when the controller is free

    // ------------------------------------------------------------
    // Controller
    // ------------------------------------------------------------

    dcache_controller u_ctrl (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_addr      (cpu_addr.fields),
        .i_re        (i_re),
        .i_we        (i_we),
        .i_be        (i_be),
        .i_wdata     (i_wdata),
        .i_hit       (sel_hit),
        .i_hit_way   (sel_hit_way),
        .i_mem_rdata (i_mem_rdata),
        .i_mem_busy  (i_mem_busy),
        .o_req       (ctrl_req),
        .o_mem_re    (o_mem_re),
        .o_mem_we    (o_mem_we),
        .o_busy      (ctrl_busy)
    );

    // ------------------------------------------------------------
    // Ways and hit merge
    // ------------------------------------------------------------

    for (genvar g = 0; g < `DCACHE_WAYS; g++) begin : g_way
        cache_set u_set (
            .i_clock   (i_clock),
            .i_reset   (i_reset),
            .i_req     (ctrl_req),
            .i_way_sel (ctrl_req.way_sel[g]),
            .o_resp    (way_resp[g])
        );
    end

    way_select u_sel (
        .i_resp    (way_resp),
        .o_hit     (sel_hit),
        .o_hit_way (sel_hit_way),
        .o_rdata   (o_rdata)
    );

endmodule

/* verilog/way_select.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module way_select (
    input  core_defs_pkg::way_resp_t i_resp [`DCACHE_WAYS],  // One per way
    output logic                     o_hit,
    output logic [`DCACHE_WAYS-1:0]  o_hit_way,              // One-hot
    output core_defs_pkg::data_t     o_rdata
);

    import core_defs_pkg::*;

    // Lowest hitting way wins, keeps the select one-hot
    always_comb begin
        o_hit     = 1'b0;
        o_hit_way = '0;
        o_rdata   = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (i_resp[w].hit && !o_hit) begin
                o_hit        = 1'b1;
                o_hit_way[w] = 1'b1;
                o_rdata      = i_resp[w].rdata;
            end
        end
    end

endmodule

/* verilog/cache_set.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module cache_set (
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  core_defs_pkg::way_req_t  i_req,      // Shared controller request
    input  logic                     i_way_sel,  // This way is the target
    output core_defs_pkg::way_resp_t o_resp
);

    import core_defs_pkg::*;

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------

    logic [`DCACHE_LINES-1:0] valid;
    tag_t                     tag_mem  [`DCACHE_LINES];
    data_t                    data_mem [`DCACHE_LINES][`DCACHE_BLOCK];

    logic                     fill_en;   // Fill aimed at this way
    logic                     write_en;  // Fill or update aimed at this way

    assign fill_en  = i_req.fill & i_way_sel;
    assign write_en = (i_req.fill | i_req.update) & i_way_sel;

    // Valid bits, cleared by reset and by the sweep
    always_ff @(posedge i_clock) begin
        if (i_reset)
            valid <= '0;
        else if (i_req.clear)
            valid[i_req.index] <= 1'b0;
        else if (fill_en)
            valid[i_req.index] <= 1'b1;
    end

    always_ff @(posedge i_clock) begin
        if (fill_en)
            tag_mem[i_req.index] <= i_req.tag;
    end

    // Byte lanes written under the request mask
    always_ff @(posedge i_clock) begin
        if (write_en) begin
            for (int b = 0; b < 4; b++) begin
                if (i_req.be[b])
                    data_mem[i_req.index][i_req.offset][8*b +: 8] <= i_req.wdata[8*b +: 8];
            end
        end
    end

    // ------------------------------------------------------------
    // Lookup
    // ------------------------------------------------------------

    assign o_resp.hit   = valid[i_req.index] && (tag_mem[i_req.index] == i_req.tag);
    assign o_resp.rdata = data_mem[i_req.index][i_req.offset];

endmodule

/* verilog/dcache_controller.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_controller (
    // Clock and reset
    input  logic                       i_clock,
    input  logic                       i_reset,

    // CPU request
    input  core_defs_pkg::addr_fields_t i_addr,     // Address split into fields
    input  logic                       i_re,        // Read held by CPU
    input  logic                       i_we,        // Write held by CPU
    input  core_defs_pkg::byte_mask_t  i_be,        // Write byte mask
    input  core_defs_pkg::data_t       i_wdata,     // Write word

    // Lookup result from way select
    input  logic                       i_hit,
    input  logic [`DCACHE_WAYS-1:0]    i_hit_way,

    // Memory side
    input  core_defs_pkg::data_t       i_mem_rdata, // Fill word
    input  logic                       i_mem_busy,  // Transfer stalls while high

    // Outputs
    output core_defs_pkg::way_req_t    o_req,       // Broadcast to every way
    output logic                       o_mem_re,
    output logic                       o_mem_we,
    output logic                       o_busy
);

    import core_defs_pkg::*;

    localparam int LAST_INDEX  = `DCACHE_LINES - 1;
    localparam int LAST_OFFSET = `DCACHE_BLOCK - 1;

    typedef enum logic [1:0] {
        S_CLEAR,  // Invalidate sweep after reset
        S_IDLE,   // Lookups served combinationally
        S_FILL,   // Line fill from memory
        S_WRITE   // Write-through to memory
    } state_t;

    state_t                  state;
    index_t                  clear_idx;  // Sweep position
    offset_t                 fill_off;   // Next word of the fill
    logic [`DCACHE_WAYS-1:0] victim;     // Round-robin, one-hot

    // ------------------------------------------------------------
    // State and counters
    // ------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state     <= S_CLEAR;
            clear_idx <= '0;
            fill_off  <= '0;
            victim    <= `DCACHE_WAYS'(1);
        end else begin
            case (state)
                S_CLEAR: begin
                    clear_idx <= clear_idx + 1'b1;
                    if (clear_idx == index_t'(LAST_INDEX))
                        state <= S_IDLE;
                end
                S_IDLE: begin
                    fill_off <= '0;                       // Fills start at word 0
                    if (i_we)
                        state <= S_WRITE;
                    else if (i_re && !i_hit)
                        state <= S_FILL;
                end
                S_FILL: begin
                    if (!i_mem_busy) begin
                        fill_off <= fill_off + 1'b1;
                        if (fill_off == offset_t'(LAST_OFFSET)) begin
                            // Rotate victim once the whole line is in
                            victim <= (victim << 1) | `DCACHE_WAYS'(victim[`DCACHE_WAYS-1]);
                            state  <= S_IDLE;
                        end
                    end
                end
                S_WRITE: begin
                    if (!i_mem_busy)
                        state <= S_IDLE;                  // Memory took the word
                end
                default: state <= S_CLEAR;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Way request and handshake outputs
    // ------------------------------------------------------------

    always_comb begin
        o_req        = '0;
        o_req.tag    = i_addr.tag;
        o_req.index  = i_addr.index;
        o_req.offset = i_addr.offset;
        o_req.be     = i_be;
        o_req.wdata  = i_wdata;
        o_mem_re     = 1'b0;
        o_mem_we     = 1'b0;
        o_busy       = 1'b1;

        case (state)
            S_CLEAR: begin
                o_req.index = clear_idx;
                o_req.clear = 1'b1;
            end
            S_IDLE: begin
                o_busy = i_we | (i_re & ~i_hit);          // Read hit completes now
            end
            S_FILL: begin
                o_req.offset  = fill_off;
                o_req.fill    = ~i_mem_busy;              // Capture on accepted read
                o_req.way_sel = victim;
                o_req.be      = '1;
                o_req.wdata   = i_mem_rdata;
                o_mem_re      = 1'b1;
            end
            S_WRITE: begin
                o_req.update  = ~i_mem_busy & i_hit;      // Only a resident word
                o_req.way_sel = i_hit_way;
                o_mem_we      = 1'b1;
                o_busy        = i_mem_busy;
            end
            default: ;
        endcase
    end

endmodule

/* verilog/core_defs_pkg.sv */
`include "dcache_defines.svh"

package core_defs_pkg;

    typedef logic [31:0]                       data_t;      // One CPU word
    typedef logic [3:0]                        byte_mask_t; // One bit per byte
    typedef logic [`DCACHE_ADDR_WIDTH-1:0]     data_addr_t; // Flat byte address

    typedef logic [`DCACHE_TAG_WIDTH-1:0]      tag_t;
    typedef logic [`DCACHE_INDEX_WIDTH-1:0]    index_t;
    typedef logic [`DCACHE_OFFSET_WIDTH-1:0]   offset_t;

    // Address split as the ways see it
    typedef struct packed {
        tag_t       tag;       // Compared against the tag array
        index_t     index;     // Line within a way
        offset_t    offset;    // Word within the line
        logic [1:0] byte_off;  // Byte within the word
    } addr_fields_t;

    // Same address word, flat toward memory or split toward the ways
    typedef union packed {
        data_addr_t   flat;
        addr_fields_t fields;
    } data_addr_u;

    // ------------------------------------------------------------
    // Controller to way broadcast
    // ------------------------------------------------------------

    typedef struct packed {
        tag_t                    tag;
        index_t                  index;
        offset_t                 offset;
        logic                    fill;     // Write a fill word, set tag and valid
        logic [`DCACHE_WAYS-1:0] way_sel;  // One-hot target of fill or update
        logic                    update;   // Masked write of a resident word
        logic                    clear;    // Drop valid at index in every way
        byte_mask_t              be;       // Bytes written on fill or update
        data_t                   wdata;
    } way_req_t;

    typedef struct packed {
        logic  hit;    // Valid and tag match at index
        data_t rdata;  // Stored word at index and offset
    } way_resp_t;

endpackage

/* verilog/dcache_defines.svh */
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// ------------------------------------------------------------
// Cache geometry
// ------------------------------------------------------------

`define DCACHE_ADDR_WIDTH   32                        // Byte address bits
`define DCACHE_LINES        16                        // Lines per way
`define DCACHE_BLOCK        4                         // Words per line
`define DCACHE_WAYS         2                         // Associativity

`define DCACHE_INDEX_WIDTH  $clog2(`DCACHE_LINES)     // Line select bits
`define DCACHE_OFFSET_WIDTH $clog2(`DCACHE_BLOCK)     // Word select bits
`define DCACHE_TAG_WIDTH    (`DCACHE_ADDR_WIDTH - 2 - `DCACHE_INDEX_WIDTH - `DCACHE_OFFSET_WIDTH)

`endif
